// File: src/soc_bus_pkg.sv
// Bus types shared by the port and its targets
// Request, access and address union, region codes and data word

package soc_bus_pkg;

    typedef logic [31:0] word_t;

    // Upper address nibble selects the target
    typedef enum logic [3:0] {
        region_dmem = 4'h1,
        region_io   = 4'h8
    } region_t;

    // ========================================
    // One address word, two decodes
    // ========================================
    typedef struct packed {
        logic [3:0]  region;
        logic [15:0] unused;
        logic [9:0]  word_idx;
        logic [1:0]  byte_off;
    } mem_addr_t;

    typedef struct packed {
        logic [3:0]  region;
        logic [19:0] unused;
        logic [7:0]  reg_off;
    } io_addr_t;

    typedef union packed {
        mem_addr_t mem;
        io_addr_t  io;
    } bus_addr_t;

    // Zero mask with write clear is a read
    typedef struct packed {
        bus_addr_t  addr;
        word_t      wdata;
        logic [3:0] wmask;
        logic       write;
    } bus_req_t;

    // Per-target access, index is word index or register offset
    typedef struct packed {
        logic [20:0] rsvd;
        logic [9:0]  index;
        word_t       wdata;
        logic [3:0]  wmask;
        logic        write;
        logic        strobe;
    } access_t;

endpackage

// File: src/soc_io_map_pkg.sv
// I/O register map
// Register offsets, GPIO width and counter width

package soc_io_map_pkg;

    typedef logic [7:0] io_off_t;

    // ========================================
    // Register offsets within the I/O region
    // ========================================

    // Free-running cycle counter, read only
    localparam io_off_t io_off_cycles = 8'h10;

    // Retired-instruction counter
    // byte 0 write clears both counters
    localparam io_off_t io_off_retired = 8'h18;

    // GPIO, byte 0 is out and byte 2 is output enable
    localparam io_off_t io_off_gpio = 8'h1C;

    // ========================================
    // Widths
    // ========================================
    localparam int gpio_width  = 8;
    localparam int count_width = 32;

endpackage

// File: src/data_sram.sv
// Banked data memory with byte write masks
// Registered read through the bank mux
`timescale 1ns/10ps

module data_sram import soc_bus_pkg::*; #(
    parameter int mem_addr_width  = 10,
    parameter int bank_addr_width = 9
) (
    input  logic    clk,
    input  access_t acc,
    output word_t   rdata
);

    localparam int sel_width  = mem_addr_width - bank_addr_width;
    localparam int bank_count = 1 << sel_width;
    localparam int bank_depth = 1 << bank_addr_width;

    // Byte lanes per word for masked writes
    logic [3:0][7:0] mem [bank_count][bank_depth];

    logic [mem_addr_width-1:0]  word_addr;
    logic [sel_width-1:0]       bank_sel;
    logic [bank_addr_width-1:0] bank_addr;
    logic [bank_count-1:0]      bank_en;

    // ========================================
    // Address split
    // ========================================
    assign word_addr = mem_addr_width'(acc.index);
    assign bank_sel  = word_addr[bank_addr_width +: sel_width];
    assign bank_addr = word_addr[bank_addr_width-1:0];

    // One-hot bank enable
    assign bank_en = {bank_count{acc.strobe}} & (bank_count'(1) << bank_sel);

    // ========================================
    // Write and registered read
    // ========================================
    always_ff @(posedge clk) begin
        for (int b = 0; b < bank_count; b++) begin
            for (int i = 0; i < 4; i++) begin
                if (bank_en[b] && acc.write && acc.wmask[i]) begin
                    mem[b][bank_addr][i] <= acc.wdata[8*i +: 8];
                end
            end
        end

        // Old word on a write, port drops it anyway
        if (acc.strobe) begin
            rdata <= mem[bank_sel][bank_addr];
        end
    end

endmodule

// File: src/io_regs.sv
// I/O register block
// GPIO out and enable, cycle and retire counters, registered read
`timescale 1ns/10ps

module io_regs import soc_bus_pkg::*, soc_io_map_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  access_t               acc,
    input  logic                  retire,
    input  logic [gpio_width-1:0] gpio_in,
    output logic [gpio_width-1:0] gpio_out,
    output logic [gpio_width-1:0] gpio_oeb,
    output word_t                 rdata
);

    logic [count_width-1:0] cycles;
    logic [count_width-1:0] retired;

    io_off_t off;
    logic    wr_en;
    logic    clear;
    word_t   rd_word;

    assign off   = acc.index[7:0];
    assign wr_en = acc.strobe && acc.write;

    // Shared clear for both counters
    assign clear = wr_en && acc.wmask[0] && (off == io_off_retired);

    // ========================================
    // GPIO registers
    // ========================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            gpio_out <= '0;
            gpio_oeb <= '0;
        end else if (wr_en && (off == io_off_gpio)) begin
            if (acc.wmask[0]) begin
                gpio_out <= acc.wdata[gpio_width-1:0];
            end
            if (acc.wmask[2]) begin
                gpio_oeb <= acc.wdata[16 +: gpio_width];
            end
        end
    end

    // ========================================
    // Status counters
    // ========================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cycles  <= '0;
            retired <= '0;
        end else if (clear) begin
            cycles  <= '0;
            retired <= '0;
        end else begin
            cycles  <= cycles + 1'b1;
            retired <= retired + count_width'(retire);
        end
    end

    // Read decode, unknown offsets give zero
    always_comb begin
        rd_word = '0;
        case (off)
            io_off_cycles:  rd_word = word_t'(cycles);
            io_off_retired: rd_word = word_t'(retired);
            io_off_gpio: begin
                rd_word[16 +: gpio_width]  = gpio_oeb;
                rd_word[gpio_width-1:0]    = gpio_in;
            end
            default:        rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (acc.strobe) begin
            rdata <= rd_word;
        end
    end

endmodule

// File: src/bus_port.sv
// Bus port with four-phase req/ack handshake
// Region decode, per-target access strobes and response select
`timescale 1ns/10ps

module bus_port import soc_bus_pkg::*; #(
    parameter int mem_addr_width = 10
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     req,
    input  bus_req_t req_data,
    output logic     ack,
    output word_t    rsp_data,
    output access_t  mem_acc,
    output access_t  io_acc,
    input  word_t    mem_rdata,
    input  word_t    io_rdata
);

    // Index bits beyond the memory size are dropped
    localparam logic [9:0] index_mask = 10'((1 << mem_addr_width) - 1);

    typedef enum logic [1:0] {
        st_idle,
        st_access,
        st_respond,
        st_release
    } state_t;

    state_t     state;
    logic [3:0] region;
    logic       hit_mem;
    logic       hit_io;
    logic       start;

    access_t acc_base;
    access_t mem_next;
    access_t io_next;
    access_t mem_q;
    access_t io_q;
    logic    mem_stb;
    logic    io_stb;

    // Region of the pending read, both clear for writes
    logic sel_mem;
    logic sel_io;

    // ========================================
    // Region decode
    // ========================================
    assign region  = req_data.addr.mem.region;
    assign hit_mem = (region == region_dmem);
    assign hit_io  = (region == region_io);
    assign start   = (state == st_idle) && req;

    always_comb begin
        acc_base       = '0;
        acc_base.wdata = req_data.wdata;
        acc_base.wmask = req_data.wmask;
        acc_base.write = req_data.write;

        mem_next       = acc_base;
        mem_next.index = req_data.addr.mem.word_idx & index_mask;

        io_next        = acc_base;
        io_next.index  = {2'b00, req_data.addr.io.reg_off};
    end

    // ========================================
    // Handshake FSM
    // ========================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= st_idle;
            mem_stb <= 1'b0;
            io_stb  <= 1'b0;
            sel_mem <= 1'b0;
            sel_io  <= 1'b0;
            ack     <= 1'b0;
        end else begin
            // Single-cycle strobe right after the sampling edge
            mem_stb <= start && hit_mem;
            io_stb  <= start && hit_io;

            case (state)
                st_idle: begin
                    if (req) begin
                        sel_mem <= hit_mem && !req_data.write;
                        sel_io  <= hit_io && !req_data.write;
                        state   <= st_access;
                    end
                end
                st_access: state <= st_respond;
                st_respond: begin
                    ack   <= 1'b1;
                    state <= st_release;
                end
                st_release: begin
                    // Hold ack while the master keeps req high
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Access payload and response word
    always_ff @(posedge clk) begin
        if (start) begin
            mem_q <= mem_next;
            io_q  <= io_next;
        end
        if (state == st_respond) begin
            rsp_data <= sel_mem ? mem_rdata : (sel_io ? io_rdata : '0);
        end
    end

    always_comb begin
        mem_acc        = mem_q;
        mem_acc.strobe = mem_stb;
        io_acc         = io_q;
        io_acc.strobe  = io_stb;
    end

endmodule

// File: src/soc_mmio_top.sv
// Memory-mapped back end top level
// Bus port, data memory and I/O register block
`timescale 1ns/10ps

module soc_mmio_top import soc_bus_pkg::*, soc_io_map_pkg::*; #(
    parameter int mem_addr_width  = 10,
    parameter int bank_addr_width = 9
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req,
    input  bus_req_t              req_data,
    output logic                  ack,
    output word_t                 rsp_data,
    input  logic                  retire,
    input  logic [gpio_width-1:0] gpio_in,
    output logic [gpio_width-1:0] gpio_out,
    output logic [gpio_width-1:0] gpio_oeb
);

    access_t mem_acc;
    access_t io_acc;
    word_t   mem_rdata;
    word_t   io_rdata;

    // ========================================
    // Request side
    // ========================================
    bus_port #(
        .mem_addr_width(mem_addr_width)
    ) u_bus_port (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .rsp_data (rsp_data),
        .mem_acc  (mem_acc),
        .io_acc   (io_acc),
        .mem_rdata(mem_rdata),
        .io_rdata (io_rdata)
    );

    // ========================================
    // Targets
    // ========================================
    data_sram #(
        .mem_addr_width (mem_addr_width),
        .bank_addr_width(bank_addr_width)
    ) u_data_sram (
        .clk  (clk),
        .acc  (mem_acc),
        .rdata(mem_rdata)
    );

    io_regs u_io_regs (
        .clk     (clk),
        .rst     (rst),
        .acc     (io_acc),
        .retire  (retire),
        .gpio_in (gpio_in),
        .gpio_out(gpio_out),
        .gpio_oeb(gpio_oeb),
        .rdata   (io_rdata)
    );

endmodule

// File: test/tb_vectors.svh
// Table entry type and the stimulus table for the MMIO testbench
// Each entry gives the operation, request fields, expected word and retire pulses
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

typedef enum logic [2:0] {
    op_write,
    op_read,
    op_gpio_read,
    op_pins,
    op_cycles
} op_t;

// exp_data for op_pins holds {8'h00, oeb, 8'h00, out}
typedef struct packed {
    op_t         op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  mask;
    logic [31:0] exp_data;
    logic        check;
    logic [3:0]  retires;
} vector_t;

localparam int num_vectors = 27;

// Columns: op, addr, wdata, mask, expected, check, retire pulses
vector_t vectors [num_vectors] = '{
    // Memory round trip across both banks
    '{op_write,     32'h1000_0000, 32'h1122_3344, 4'hF, 32'h0000_0000, 1'b1, 4'd0},
    '{op_write,     32'h1000_0800, 32'hA5A5_5A5A, 4'hF, 32'h0000_0000, 1'b1, 4'd0},
    '{op_write,     32'h1000_0004, 32'hDEAD_BEEF, 4'hF, 32'h0000_0000, 1'b1, 4'd0},
    '{op_write,     32'h1000_0FFC, 32'h0BAD_F00D, 4'hF, 32'h0000_0000, 1'b1, 4'd0},
    '{op_read,      32'h1000_0000, 32'h0000_0000, 4'h0, 32'h1122_3344, 1'b1, 4'd0},
    '{op_read,      32'h1000_0800, 32'h0000_0000, 4'h0, 32'hA5A5_5A5A, 1'b1, 4'd0},
    '{op_read,      32'h1000_0004, 32'h0000_0000, 4'h0, 32'hDEAD_BEEF, 1'b1, 4'd0},
    '{op_read,      32'h1000_0FFC, 32'h0000_0000, 4'h0, 32'h0BAD_F00D, 1'b1, 4'd0},
    // Partial masks keep the disabled bytes
    '{op_write,     32'h1000_0000, 32'hFFEE_DDCC, 4'h5, 32'h0000_0000, 1'b1, 4'd0},
    '{op_read,      32'h1000_0000, 32'h0000_0000, 4'h0, 32'h11EE_33CC, 1'b1, 4'd0},
    '{op_write,     32'h1000_0800, 32'h0102_0304, 4'h8, 32'h0000_0000, 1'b1, 4'd0},
    '{op_read,      32'h1000_0800, 32'h0000_0000, 4'h0, 32'h01A5_5A5A, 1'b1, 4'd0},
    // GPIO out, then output enable
    '{op_write,     32'h8000_001C, 32'h00C3_0096, 4'h1, 32'h0000_0000, 1'b1, 4'd0},
    '{op_pins,      32'h0000_0000, 32'h0000_0000, 4'h0, 32'h0000_0096, 1'b1, 4'd0},
    '{op_write,     32'h8000_001C, 32'h005A_00FF, 4'h4, 32'h0000_0000, 1'b1, 4'd0},
    '{op_pins,      32'h0000_0000, 32'h0000_0000, 4'h0, 32'h005A_0096, 1'b1, 4'd0},
    '{op_gpio_read, 32'h8000_001C, 32'h0000_0000, 4'h0, 32'h005A_0000, 1'b1, 4'd0},
    // Counter clear, retire count, cycle count
    '{op_write,     32'h8000_0018, 32'h0000_0000, 4'h1, 32'h0000_0000, 1'b1, 4'd0},
    '{op_read,      32'h8000_0018, 32'h0000_0000, 4'h0, 32'h0000_0005, 1'b1, 4'd5},
    '{op_cycles,    32'h8000_0010, 32'h0000_0000, 4'h0, 32'h0000_0000, 1'b1, 4'd0},
    '{op_cycles,    32'h8000_0010, 32'h0000_0000, 4'h0, 32'h0000_0000, 1'b1, 4'd2},
    '{op_read,      32'h8000_0018, 32'h0000_0000, 4'h0, 32'h0000_0007, 1'b1, 4'd0},
    // Unmapped region
    '{op_read,      32'h4000_0000, 32'h0000_0000, 4'h0, 32'h0000_0000, 1'b1, 4'd0},
    '{op_write,     32'h4000_0000, 32'hFFFF_FFFF, 4'hF, 32'h0000_0000, 1'b1, 4'd0},
    '{op_write,     32'h4000_001C, 32'hFFFF_FFFF, 4'hF, 32'h0000_0000, 1'b1, 4'd0},
    '{op_read,      32'h1000_0000, 32'h0000_0000, 4'h0, 32'h11EE_33CC, 1'b1, 4'd0},
    '{op_pins,      32'h0000_0000, 32'h0000_0000, 4'h0, 32'h005A_0096, 1'b1, 4'd0}
};

`endif

// File: test/tb_soc_mmio.sv
// Testbench for the MMIO back end
// Clock and reset, four-phase master, check task, timeout and table loop
`timescale 1ns/10ps

module tb_soc_mmio import soc_bus_pkg::*;;

    `include "tb_vectors.svh"

    localparam int max_cycles = num_vectors * 20 + 200;

    logic       clk;
    logic       rst;
    logic       req;
    bus_req_t   req_data;
    logic       ack;
    word_t      rsp_data;
    logic       retire;
    logic [7:0] gpio_in;
    logic [7:0] gpio_out;
    logic [7:0] gpio_oeb;

    int unsigned cycle_count;
    logic [31:0] pulses_since_clear;
    logic [31:0] prev_cycles;
    logic        have_prev_cycles;

    soc_mmio_top #(
        .mem_addr_width (10),
        .bank_addr_width(9)
    ) uut (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .req_data(req_data),
        .ack     (ack),
        .rsp_data(rsp_data),
        .retire  (retire),
        .gpio_in (gpio_in),
        .gpio_out(gpio_out),
        .gpio_oeb(gpio_oeb)
    );

    always #10 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("Error: run did not finish within %0d cycles", max_cycles);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        if (actual !== expected) begin
            $display("Mismatch at time %0t: %s, got %h, expected %h",
                     $time, msg, actual, expected);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // ========================================
    // Master side
    // ========================================
    task automatic do_transaction(input bus_req_t r, output word_t data);
        @(posedge clk);
        req_data <= r;
        req      <= 1'b1;
        do @(posedge clk); while (ack !== 1'b1);
        data = rsp_data;
        req <= 1'b0;
        do @(posedge clk); while (ack !== 1'b0);
    endtask

    // One-cycle pulses with a gap, master idle
    task automatic give_retires(input logic [3:0] n);
        repeat (n) begin
            @(posedge clk);
            retire <= 1'b1;
            @(posedge clk);
            retire <= 1'b0;
        end
        pulses_since_clear = pulses_since_clear + 32'(n);
    endtask

    task automatic run_vector(input int idx, input vector_t v);
        bus_req_t    r;
        word_t       data;
        logic [31:0] exp_word;
        string       msg;

        msg = $sformatf("entry %0d at address %h", idx, v.addr);
        @(posedge clk);
        gpio_in <= 8'($urandom);
        give_retires(v.retires);

        if (v.op == op_pins) begin
            @(posedge clk);
            check_equal({8'h00, gpio_oeb, 8'h00, gpio_out}, v.exp_data, msg);
        end else begin
            r       = '0;
            r.addr  = v.addr;
            r.wdata = v.wdata;
            r.write = (v.op == op_write);
            r.wmask = (v.op == op_write) ? v.mask : 4'h0;
            do_transaction(r, data);

            case (v.op)
                op_cycles: begin
                    check_equal(32'(data >= pulses_since_clear), 32'd1, msg);
                    if (have_prev_cycles) begin
                        check_equal(32'(data > prev_cycles), 32'd1, msg);
                    end
                    prev_cycles      = data;
                    have_prev_cycles = 1'b1;
                end
                op_gpio_read: begin
                    // gpio_in held since the start of this entry
                    exp_word = v.exp_data | {24'h0, gpio_in};
                    check_equal(data, exp_word, msg);
                end
                default: begin
                    if (v.check) begin
                        check_equal(data, v.exp_data, msg);
                    end
                end
            endcase

            // Write to the retire counter with byte 0 clears both counters
            if (v.op == op_write && v.addr[31:28] == 4'h8 && v.addr[7:0] == 8'h18
                    && v.mask[0]) begin
                pulses_since_clear = '0;
                have_prev_cycles   = 1'b0;
            end
        end
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        clk                = 1'b0;
        rst                = 1'b1;
        req                = 1'b0;
        req_data           = '0;
        retire             = 1'b0;
        gpio_in            = '0;
        cycle_count        = 0;
        pulses_since_clear = '0;
        prev_cycles        = '0;
        have_prev_cycles   = 1'b0;
        void'($urandom(40044));

        repeat (3) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < num_vectors; i++) begin
            run_vector(i, vectors[i]);
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+test
src/soc_bus_pkg.sv
src/soc_io_map_pkg.sv
src/data_sram.sv
src/io_regs.sv
src/bus_port.sv
src/soc_mmio_top.sv
test/tb_soc_mmio.sv

// File: Makefile
# Verilator build and run for the MMIO back end

TOP = tb_soc_mmio

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): filelist.f src/*.sv test/*.sv test/*.svh
	verilator --binary --timing -j 0 -f filelist.f --top-module $(TOP) -Mdir obj_dir

run: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@grep -q "Simulation passed" sim.log || (echo "Run failed, see sim.log"; exit 1)

lint:
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
